// ==== all.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mips_core.sv
dv/wb_checker.sv
dv/tb_mips_core.sv

// ==== dv/tb_mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module tb_mips_core import mips_pkg::*; ();

    localparam int N_INS    = 2000;
    localparam int MAX_CYC  = 10000;
    localparam int DRAIN_TO = 20;

    localparam logic [5:0] R_FN [13] = '{`FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLLV,
        `FN_SRLV, `FN_SRAV, `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU};
    localparam logic [5:0] S_FN [3] = '{`FN_SLL, `FN_SRL, `FN_SRA};
    localparam logic [5:0] I_OP [8] = '{`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_ADDI,
        `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
    localparam logic [15:0] IMM_EDGE [4] = '{16'h7fff, 16'h8000, 16'hffff, 16'h0001};
    localparam logic [5:0] BAD_OP [4] = '{6'b100011, 6'b101011, 6'b000100, 6'b011100};
    localparam logic [5:0] BAD_FN [3] = '{6'b011000, 6'b010000, 6'b001000};  // mult, mfhi, jr

    logic       clk;
    logic       rst_n;
    logic       ins_valid;
    word_t      ins;
    logic       wb_en;
    reg_addr_t  wb_addr;
    word_t      wb_data;
    logic       bad_ins;
    logic [1:0] pending;
    int         chk_errors;
    int         tb_errors;
    integer     seed;

    mips_core uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ins_valid (ins_valid),
        .ins       (ins),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .bad_ins   (bad_ins)
    );

    wb_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .ins_valid (ins_valid),
        .ins       (ins),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .bad_ins   (bad_ins),
        .pending   (pending),
        .errors    (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic drive_slot(input logic vld, input word_t w);
        @(negedge clk);
        ins_valid = vld;
        ins       = w;
    endtask

    // registers limited to r0..r7 so hazards come often
    task automatic pick_ins(output word_t w);
        int          kind;
        reg_addr_t   rs, rt, rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        kind = {$random(seed)} % 20;
        rs   = reg_addr_t'({$random(seed)} % 8);
        rt   = reg_addr_t'({$random(seed)} % 8);
        rd   = reg_addr_t'({$random(seed)} % 8);
        sa   = 5'($random(seed));
        imm  = 16'($random(seed));
        if ({$random(seed)} % 4 == 0) imm = IMM_EDGE[{$random(seed)} % 4];
        if (kind < 7) w = {`OP_SPECIAL, rs, rt, rd, 5'd0, R_FN[{$random(seed)} % 13]};
        else if (kind < 9) w = {`OP_SPECIAL, 5'd0, rt, rd, sa, S_FN[{$random(seed)} % 3]};
        else if (kind < 16) w = {I_OP[{$random(seed)} % 8], rs, rt, imm};
        else if (kind == 16) w = {26'd0, `FN_SYNC};
        else if (kind == 17) w = {`OP_PREF, rs, rt, imm};
        else if (kind == 18) w = {BAD_OP[{$random(seed)} % 4], 26'($random(seed))};
        else w = {`OP_SPECIAL, 20'($random(seed)), BAD_FN[{$random(seed)} % 3]};
    endtask

    initial begin
        word_t w;
        int    sent;
        int    cycles;
        seed      = 40435;
        tb_errors = 0;
        sent      = 0;
        cycles    = 0;
        rst_n     = 1'b0;
        ins_valid = 1'b0;
        ins       = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // untouched registers read zero
        for (int r = 1; r < `REG_NUM; r++) begin
            drive_slot(1'b1, {`OP_SPECIAL, reg_addr_t'(r), 5'd0, reg_addr_t'(r), 5'd0, `FN_ADDU});
        end
        drive_slot(1'b1, {`OP_LUI, 5'd0, 5'd1, 16'h7fff});
        drive_slot(1'b1, {`OP_ORI, 5'd1, 5'd1, 16'hffff});
        drive_slot(1'b1, {`OP_ADDI, 5'd1, 5'd2, 16'h0001});    // overflows so nothing is written
        drive_slot(1'b1, {`OP_SPECIAL, 5'd1, 5'd1, 5'd3, 5'd0, `FN_ADDU});
        drive_slot(1'b1, {`OP_LUI, 5'd0, 5'd5, 16'h8000});
        drive_slot(1'b1, {`OP_ORI, 5'd0, 5'd6, 16'h0001});
        drive_slot(1'b1, {`OP_SPECIAL, 5'd5, 5'd6, 5'd7, 5'd0, `FN_SUB});
        drive_slot(1'b1, {`OP_SPECIAL, 5'd5, 5'd6, 5'd4, 5'd0, `FN_SUBU});

        while (sent < N_INS && cycles < MAX_CYC) begin
            if ({$random(seed)} % 10 < 8) begin
                pick_ins(w);
                drive_slot(1'b1, w);
                sent++;
            end else begin
                drive_slot(1'b0, word_t'($random(seed)));   // ignored slot
            end
            cycles++;
        end
        if (sent < N_INS) begin
            tb_errors++;
            $display("timeout: only %0d of %0d instructions issued in %0d cycles",
                     sent, N_INS, MAX_CYC);
        end
        drive_slot(1'b0, '0);

        cycles = 0;
        while (pending != 0 && cycles < DRAIN_TO) begin
            @(negedge clk);
            cycles++;
        end
        if (pending != 0) begin
            tb_errors++;
            $display("timeout: pipeline did not drain within %0d cycles", DRAIN_TO);
        end

        $display("error counts: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/wb_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module wb_checker import mips_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        ins_valid,
    input  word_t      ins,
    input  wire        wb_en,
    input  reg_addr_t  wb_addr,
    input  word_t      wb_data,
    input  wire        bad_ins,
    output logic [1:0] pending,
    output int         errors
);

    typedef struct packed {
        logic    live;
        logic    bad;
        commit_t wr;
        word_t   ins;
    } expect_t;

    word_t   model [`REG_NUM];
    expect_t exp1;    // bad_ins due at the next edge
    expect_t exp2;    // commit due at the next edge

    // architectural effect of one instruction on the model registers
    function automatic commit_t ref_exec(input word_t w, output logic bad);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  sa;
        reg_addr_t   rs, rt;
        word_t       vs, vt, imm_s, imm_z;
        logic [32:0] wide;
        commit_t     c;
        opc   = w[31:26];
        rs    = w[25:21];
        rt    = w[20:16];
        sa    = w[10:6];
        fn    = w[5:0];
        vs    = model[rs];
        vt    = model[rt];
        imm_s = {{16{w[15]}}, w[15:0]};
        imm_z = {16'h0, w[15:0]};
        bad   = 1'b0;
        c.en  = 1'b1;
        c.addr = (opc == `OP_SPECIAL) ? w[15:11] : rt;
        c.data = '0;
        case (opc)
            `OP_SPECIAL: begin
                case (fn)
                    `FN_SLL:  c.data = vt << sa;
                    `FN_SRL:  c.data = vt >> sa;
                    `FN_SRA:  c.data = word_t'($signed(vt) >>> sa);
                    `FN_SLLV: c.data = vt << vs[4:0];
                    `FN_SRLV: c.data = vt >> vs[4:0];
                    `FN_SRAV: c.data = word_t'($signed(vt) >>> vs[4:0]);
                    `FN_AND:  c.data = vs & vt;
                    `FN_OR:   c.data = vs | vt;
                    `FN_XOR:  c.data = vs ^ vt;
                    `FN_NOR:  c.data = ~(vs | vt);
                    `FN_ADDU: c.data = vs + vt;
                    `FN_SUBU: c.data = vs - vt;
                    `FN_SLT:  c.data = {31'd0, $signed(vs) < $signed(vt)};
                    `FN_SLTU: c.data = {31'd0, vs < vt};
                    `FN_SYNC: c.en = 1'b0;
                    `FN_ADD: begin
                        wide   = {vs[31], vs} + {vt[31], vt};
                        c.data = wide[31:0];
                        c.en   = (wide[32] == wide[31]);  // sign bits agree, no overflow
                    end
                    `FN_SUB: begin
                        wide   = {vs[31], vs} - {vt[31], vt};
                        c.data = wide[31:0];
                        c.en   = (wide[32] == wide[31]);
                    end
                    default:  bad = 1'b1;
                endcase
                if (fn == `FN_SLL || fn == `FN_SRL || fn == `FN_SRA) begin
                    if (rs != '0) bad = 1'b1;       // constant shifts need rs zero
                end else if (sa != '0) begin
                    bad = 1'b1;
                end
            end
            `OP_ANDI:  c.data = vs & imm_z;
            `OP_ORI:   c.data = vs | imm_z;
            `OP_XORI:  c.data = vs ^ imm_z;
            `OP_LUI:   c.data = {w[15:0], 16'h0};
            `OP_ADDIU: c.data = vs + imm_s;
            `OP_SLTI:  c.data = {31'd0, $signed(vs) < $signed(imm_s)};
            `OP_SLTIU: c.data = {31'd0, vs < imm_s};
            `OP_PREF:  c.en = 1'b0;
            `OP_ADDI: begin
                wide   = {vs[31], vs} + {imm_s[31], imm_s};
                c.data = wide[31:0];
                c.en   = (wide[32] == wide[31]);
            end
            default:   bad = 1'b1;
        endcase
        if (bad || c.addr == '0) c.en = 1'b0;
        return c;
    endfunction

    always @(posedge clk) begin
        expect_t nx;
        logic    bad;
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                model[i] = '0;
            end
            errors = 0;
            exp1  <= '0;
            exp2  <= '0;
        end else begin
            if (bad_ins !== exp1.bad) begin
                errors++;
                $display("ERR %0t: bad_ins %b, expected %b for ins %h",
                         $time, bad_ins, exp1.bad, exp1.ins);
            end
            if (wb_en !== exp2.wr.en ||
                (exp2.wr.en && (wb_addr !== exp2.wr.addr || wb_data !== exp2.wr.data))) begin
                errors++;
                $display("ERR %0t: commit %b r%0d %h, expected %b r%0d %h for ins %h",
                         $time, wb_en, wb_addr, wb_data,
                         exp2.wr.en, exp2.wr.addr, exp2.wr.data, exp2.ins);
            end
            nx = '0;
            if (ins_valid) begin
                nx.live = 1'b1;
                nx.ins  = ins;
                nx.wr   = ref_exec(ins, bad);
                nx.bad  = bad;
                if (nx.wr.en) model[nx.wr.addr] = nx.wr.data;  // program order
            end
            exp1 <= nx;
            exp2 <= exp1;
        end
    end

    assign pending = {1'b0, exp1.live} + {1'b0, exp2.live};

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module decode_stage import mips_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       ins_valid,
    input  word_t     ins,
    output reg_addr_t rd1_addr,
    output reg_addr_t rd2_addr,
    input  word_t     rd1_data,
    input  word_t     rd2_data,
    input  commit_t   ex_fwd,
    input  commit_t   mem_commit,
    output id_ex_t    id_ex,
    output logic      bad_ins
);

    logic [`OPC_W-1:0]   opcode;
    logic [`SHAMT_W-1:0] sa;
    logic [`FN_W-1:0]    funct;
    reg_addr_t           rs, rt, rd;

    alu_op_e   op_dec;
    logic      rd1_en, rd2_en;
    logic      wd_en_dec;
    reg_addr_t wd_addr_dec;
    word_t     imm;
    logic      ins_ok;
    logic      r_type, i_type;
    word_t     num1, num2;

    assign opcode = ins[31:26];
    assign rs     = ins[25:21];
    assign rt     = ins[20:16];
    assign rd     = ins[15:11];
    assign sa     = ins[10:6];
    assign funct  = ins[5:0];

    assign rd1_addr = rs;
    assign rd2_addr = rt;

    always_comb begin
        op_dec      = ALU_NOP;
        rd1_en      = 1'b0;
        rd2_en      = 1'b0;
        wd_en_dec   = 1'b0;
        wd_addr_dec = rd;     // R-type default
        ins_ok      = 1'b0;
        r_type      = 1'b1;
        i_type      = 1'b1;
        case (opcode)
            `OP_ANDI, `OP_ORI, `OP_XORI: imm = {16'h0, ins[15:0]};
            `OP_LUI:                     imm = {ins[15:0], 16'h0};
            default:                     imm = {{16{ins[15]}}, ins[15:0]};
        endcase
        case (opcode)
            `OP_SPECIAL: begin
                i_type = 1'b0;
                case (funct)
                    `FN_AND:  op_dec = ALU_AND;
                    `FN_OR:   op_dec = ALU_OR;
                    `FN_XOR:  op_dec = ALU_XOR;
                    `FN_NOR:  op_dec = ALU_NOR;
                    `FN_SLLV: op_dec = ALU_SLL;  // amount from rs
                    `FN_SRLV: op_dec = ALU_SRL;
                    `FN_SRAV: op_dec = ALU_SRA;
                    `FN_ADD:  op_dec = ALU_ADD;
                    `FN_ADDU: op_dec = ALU_ADDU;
                    `FN_SUB:  op_dec = ALU_SUB;
                    `FN_SUBU: op_dec = ALU_SUBU;
                    `FN_SLT:  op_dec = ALU_SLT;
                    `FN_SLTU: op_dec = ALU_SLTU;
                    default:  r_type = 1'b0;
                endcase
                if (sa != '0) begin
                    r_type = 1'b0;
                end
                if (sa == '0 && funct == `FN_SYNC) begin
                    ins_ok = 1'b1;       // treated as nop
                end
            end
            `OP_ANDI:  op_dec = ALU_AND;
            `OP_ORI:   op_dec = ALU_OR;
            `OP_XORI:  op_dec = ALU_XOR;
            `OP_LUI:   op_dec = ALU_OR;
            `OP_ADDI:  op_dec = ALU_ADD;
            `OP_ADDIU: op_dec = ALU_ADDU;
            `OP_SLTI:  op_dec = ALU_SLT;
            `OP_SLTIU: op_dec = ALU_SLTU;
            `OP_PREF: begin
                r_type = 1'b0;
                i_type = 1'b0;
                ins_ok = 1'b1;       // prefetch hint has no effect
            end
            default: begin
                r_type = 1'b0;
                i_type = 1'b0;
            end
        endcase

        if (r_type) begin
            rd1_en    = 1'b1;
            rd2_en    = 1'b1;
            wd_en_dec = 1'b1;
            ins_ok    = 1'b1;
        end
        if (i_type) begin
            rd1_en      = (opcode != `OP_LUI);  // lui ors imm with itself
            rd2_en      = 1'b0;
            wd_en_dec   = 1'b1;
            wd_addr_dec = rt;
            ins_ok      = 1'b1;
        end

        // constant shifts need rs == 0
        if (ins[31:21] == '0 && (funct == `FN_SLL || funct == `FN_SRL || funct == `FN_SRA)) begin
            op_dec      = (funct == `FN_SLL) ? ALU_SLL : (funct == `FN_SRL) ? ALU_SRL : ALU_SRA;
            rd1_en      = 1'b0;
            rd2_en      = 1'b1;
            wd_en_dec   = 1'b1;
            wd_addr_dec = rd;
            imm         = {{(`DATA_W-`SHAMT_W){1'b0}}, sa};
            ins_ok      = 1'b1;
        end
    end

    // execute forward beats memory forward beats the array
    function automatic word_t pick_operand(input logic en, input reg_addr_t addr,
                                           input word_t rd_data, input word_t imm_val,
                                           input commit_t ex_c, input commit_t mem_c);
        if (!en) return imm_val;
        if (ex_c.en && ex_c.addr == addr) return ex_c.data;
        if (mem_c.en && mem_c.addr == addr) return mem_c.data;
        return rd_data;
    endfunction

    assign num1 = pick_operand(rd1_en, rs, rd1_data, imm, ex_fwd, mem_commit);
    assign num2 = pick_operand(rd2_en, rt, rd2_data, imm, ex_fwd, mem_commit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex.op    <= ALU_NOP;
            id_ex.wd_en <= 1'b0;
            bad_ins     <= 1'b0;
        end else begin
            id_ex.op    <= ins_valid ? op_dec : ALU_NOP;
            id_ex.wd_en <= ins_valid && ins_ok && wd_en_dec && (wd_addr_dec != '0);
            bad_ins     <= ins_valid && !ins_ok;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.num1    <= num1;
        id_ex.num2    <= num2;
        id_ex.wd_addr <= wd_addr_dec;
    end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module execute_stage import mips_pkg::*; (
    input  wire     clk,
    input  wire     rst_n,
    input  id_ex_t  id_ex,
    output commit_t ex_fwd,
    output commit_t mem_commit
);

    word_t               a, b;
    word_t               sum, diff;
    word_t               result;
    logic [`SHAMT_W-1:0] shamt;
    logic                ovf;

    assign a     = id_ex.num1;
    assign b     = id_ex.num2;
    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = a[`SHAMT_W-1:0];   // shifts move num2

    always_comb begin
        result = '0;
        ovf    = 1'b0;
        case (id_ex.op)
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLL:  result = b << shamt;
            ALU_SRL:  result = b >> shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> shamt);
            ALU_ADDU: result = sum;
            ALU_SUBU: result = diff;
            ALU_ADD: begin
                result = sum;
                ovf    = (a[`DATA_W-1] == b[`DATA_W-1]) && (sum[`DATA_W-1] != a[`DATA_W-1]);
            end
            ALU_SUB: begin
                result = diff;
                ovf    = (a[`DATA_W-1] != b[`DATA_W-1]) && (diff[`DATA_W-1] != a[`DATA_W-1]);
            end
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            default:  result = '0;
        endcase
    end

    // overflowing add/sub leaves rd untouched
    assign ex_fwd.en   = id_ex.wd_en && !ovf;
    assign ex_fwd.addr = id_ex.wd_addr;
    assign ex_fwd.data = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_commit.en <= 1'b0;
        end else begin
            mem_commit.en <= ex_fwd.en;
        end
    end

    always_ff @(posedge clk) begin
        mem_commit.addr <= ex_fwd.addr;
        mem_commit.data <= ex_fwd.data;
    end

endmodule

`default_nettype wire

// ==== rtl/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// machine widths
`define DATA_W      32
`define REG_ADDR_W  5
`define REG_NUM     32
`define OPC_W       6
`define FN_W        6
`define SHAMT_W     5

// primary opcodes, ins[31:26]
`define OP_SPECIAL  6'b000000
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_PREF     6'b110011

// SPECIAL funct codes, ins[5:0]
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_SYNC     6'b001111
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

`endif

// ==== rtl/mips_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_core import mips_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       ins_valid,
    input  word_t     ins,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      bad_ins
);

    reg_addr_t rd1_addr, rd2_addr;
    word_t     rd1_data, rd2_data;
    id_ex_t    id_ex;
    commit_t   ex_fwd;
    commit_t   mem_commit;

    decode_stage u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .ins_valid  (ins_valid),
        .ins        (ins),
        .rd1_addr   (rd1_addr),
        .rd2_addr   (rd2_addr),
        .rd1_data   (rd1_data),
        .rd2_data   (rd2_data),
        .ex_fwd     (ex_fwd),
        .mem_commit (mem_commit),
        .id_ex      (id_ex),
        .bad_ins    (bad_ins)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .ex_fwd     (ex_fwd),
        .mem_commit (mem_commit)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd1_addr (rd1_addr),
        .rd2_addr (rd2_addr),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .wr       (mem_commit)      // memory stage commits directly
    );

    assign wb_en   = mem_commit.en;
    assign wb_addr = mem_commit.addr;
    assign wb_data = mem_commit.data;

endmodule

`default_nettype wire

// ==== rtl/mips_pkg.sv ====
`default_nettype none

`include "mips_cfg.svh"

package mips_pkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // execute operation, immediate forms share the register-form codes
    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef struct packed {
        alu_op_e   op;
        word_t     num1;     // rs or shift amount
        word_t     num2;     // rt or immediate
        logic      wd_en;
        reg_addr_t wd_addr;
    } id_ex_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } commit_t;

endpackage

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module reg_file import mips_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  reg_addr_t rd1_addr,
    input  reg_addr_t rd2_addr,
    output word_t     rd1_data,
    output word_t     rd2_data,
    input  commit_t   wr
);

    word_t regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != '0)) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // $zero is hardwired
    assign rd1_data = (rd1_addr == '0) ? '0 : regs[rd1_addr];
    assign rd2_data = (rd2_addr == '0) ? '0 : regs[rd2_addr];

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the pipeline testbench with Verilator, run it, judge the log
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module tb_mips_core \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" "$LOG"; then
    exit 0
fi
exit 1
